// ==== files.f ====
drs_readout_pkg.sv
readout_sequencer.sv
stop_cell_shifter.sv
delay_line.sv
sample_buffer.sv
event_formatter.sv
drs_readout_top.sv
tb_drs_readout.sv

// ==== Bender.yml ====
package:
  name: drs_readout

sources:
  - files:
      - drs_readout_pkg.sv
      - readout_sequencer.sv
      - stop_cell_shifter.sv
      - delay_line.sv
      - sample_buffer.sv
      - event_formatter.sv
      - drs_readout_top.sv
  - target: test
    files:
      - tb_drs_readout.sv

// ==== tb_drs_readout.sv ====
`timescale 1ns/1ns

module tb_drs_readout;
	import drs_readout_pkg::*;

	localparam int N_EVENTS = 6;
	localparam int STROBES = CELL_W - 1 + READ_DEPTH;

	logic AD9222_FCO_P;
	logic rst;
	logic trig;
	logic [N_CHIP-1:0] drs_srout;
	adc_sample_t [N_CHIP-1:0] adc_data;
	logic tx_full;
	logic drs_rsrload;
	logic drs_srclk;
	logic [7:0] tx_data;
	logic tx_wr;
	logic busy;

	// random stop cells for each event
	stop_cell_t ev_cells [N_EVENTS][N_CHIP];
	logic [31:0] lfsr_state = 32'd86682;
	bit full_en = 0;

	int mismatches = 0;
	int failures = 0;
	int rx_total = 0;
	int load_cnt = 0;
	int srclk_cnt = 0;

	// chip and adc model state
	int model_loads = 0;
	int model_ev = 0;
	int cell_bit = 0;
	int strobe_n = 0;
	bit pipe_v [ADC_LATENCY];
	int pipe_k [ADC_LATENCY];
	int pipe_ev [ADC_LATENCY];

	drs_readout_top drs_readout_top_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.rst(rst),
		.trig(trig),
		.drs_srout(drs_srout),
		.adc_data(adc_data),
		.tx_full(tx_full),
		.drs_rsrload(drs_rsrload),
		.drs_srclk(drs_srclk),
		.tx_data(tx_data),
		.tx_wr(tx_wr),
		.busy(busy)
	);

	initial begin
		AD9222_FCO_P = 1'b0;
		forever begin
			#20 AD9222_FCO_P = ~AD9222_FCO_P;
		end
	end

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic adc_sample_t sample_value(input int ev, input int c, input int k);
		return adc_sample_t'((256 * c + k + 1 + ev) % 4096);
	endfunction

	// expected byte at position pos of event ev
	function automatic logic [7:0] expected_byte(input int ev, input int pos);
		int s;
		logic [15:0] word;
		if (pos == 0) begin
			return 8'hEB;
		end
		if (pos == 1) begin
			return 8'(ev % 256);
		end
		if (pos == EVENT_BYTES - 1) begin
			return 8'h75;
		end
		if (pos < 2 + 2 * N_CHIP) begin
			word = 16'(ev_cells[ev][(pos - 2) / 2]);
			return ((pos - 2) % 2 == 0) ? word[15:8] : word[7:0];
		end
		// samples run channel first within each readout position
		s = (pos - 2 - 2 * N_CHIP) / 2;
		word = 16'(sample_value(ev, s % N_CHIP, s / N_CHIP));
		return ((pos - 2 - 2 * N_CHIP) % 2 == 0) ? word[15:8] : word[7:0];
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// chip serial output and adc pipeline
	always @(posedge AD9222_FCO_P) begin : board_model
		bit is_read;
		int k;
		is_read = 0;
		k = 0;
		if (drs_rsrload) begin
			model_ev = model_loads;
			model_loads++;
			cell_bit = CELL_W - 1;
			strobe_n = 0;
			if (model_ev < N_EVENTS) begin
				for (int c = 0; c < N_CHIP; c++) begin
					drs_srout[c] <= ev_cells[model_ev][c][cell_bit];
				end
			end else begin
				failures++;
				$display("unexpected chip load at %0t ns, more events than triggered", $time);
			end
		end else if (drs_srclk) begin
			if (cell_bit > 0 && model_ev < N_EVENTS) begin
				cell_bit--;
				for (int c = 0; c < N_CHIP; c++) begin
					drs_srout[c] <= ev_cells[model_ev][c][cell_bit];
				end
			end
			if (strobe_n >= CELL_W - 1) begin
				is_read = 1;
				k = strobe_n - (CELL_W - 1);
			end
			strobe_n++;
		end
		for (int i = ADC_LATENCY - 1; i > 0; i--) begin
			pipe_v[i] = pipe_v[i-1];
			pipe_k[i] = pipe_k[i-1];
			pipe_ev[i] = pipe_ev[i-1];
		end
		pipe_v[0] = is_read;
		pipe_k[0] = k;
		pipe_ev[0] = model_ev;
		// sample valid in the cycle ADC_LATENCY after its strobe
		for (int c = 0; c < N_CHIP; c++) begin
			if (pipe_v[ADC_LATENCY-1]) begin
				adc_data[c] <= sample_value(pipe_ev[ADC_LATENCY-1], c, pipe_k[ADC_LATENCY-1]);
			end else begin
				adc_data[c] <= '1;
			end
		end
	end

	// byte stream against the reference
	always @(posedge AD9222_FCO_P) begin : compare_bytes
		int ev;
		int pos;
		check_equal("tx_wr high while tx_full", 32'(tx_wr === 1'b1 && tx_full === 1'b1), 0);
		if (tx_wr === 1'b1) begin
			ev = rx_total / EVENT_BYTES;
			pos = rx_total % EVENT_BYTES;
			if (ev < N_EVENTS) begin
				check_equal($sformatf("event %0d byte %0d", ev, pos), 32'(tx_data),
					32'(expected_byte(ev, pos)));
			end else begin
				failures++;
				$display("byte written at %0t ns after the last expected event", $time);
			end
			rx_total++;
		end
	end

	always @(posedge AD9222_FCO_P) begin : count_strobes
		if (drs_rsrload === 1'b1) begin
			load_cnt++;
		end
		if (drs_srclk === 1'b1) begin
			srclk_cnt++;
		end
	end

	// advance one clock and draw tx_full from the lfsr while enabled
	task automatic next_cycle();
		logic [31:0] bits;
		@(posedge AD9222_FCO_P);
		if (full_en) begin
			take_bits(1, bits);
			tx_full <= bits[0];
		end else begin
			tx_full <= 1'b0;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (busy !== level) begin
			failures++;
			$display("timeout at %0t ns: busy did not go to %0b within %0d cycles",
				$time, level, limit);
		end
	endtask

	task automatic run_event(input int ev, input bit with_full, input bit extra_trigs);
		logic [31:0] bits;
		for (int c = 0; c < N_CHIP; c++) begin
			take_bits(CELL_W, bits);
			ev_cells[ev][c] = stop_cell_t'(bits);
		end
		full_en = with_full;
		next_cycle();
		trig <= 1'b1;
		next_cycle();
		next_cycle();
		trig <= 1'b0;
		wait_busy(1'b1, 20);
		if (extra_trigs) begin
			// edges during readout must be ignored
			repeat (3) begin
				repeat (3) next_cycle();
				trig <= 1'b1;
				repeat (2) next_cycle();
				trig <= 1'b0;
			end
		end
		wait_busy(1'b0, 5000);
		full_en = 0;
		repeat (10) next_cycle();
		check_equal($sformatf("bytes after event %0d", ev), 32'(rx_total),
			32'((ev + 1) * EVENT_BYTES));
		check_equal($sformatf("loads after event %0d", ev), 32'(load_cnt), 32'(ev + 1));
		check_equal($sformatf("srclk cycles after event %0d", ev), 32'(srclk_cnt),
			32'((ev + 1) * STROBES));
		check_equal("busy after event", 32'(busy), 0);
	endtask

	initial begin
		rst = 1'b1;
		trig = 1'b0;
		tx_full = 1'b0;
		drs_srout = '0;
		adc_data = '1;
		repeat (5) @(posedge AD9222_FCO_P);
		rst <= 1'b0;

		// quiet outputs before any trigger
		repeat (10) begin
			next_cycle();
			check_equal("tx_wr after reset", 32'(tx_wr), 0);
			check_equal("drs_rsrload after reset", 32'(drs_rsrload), 0);
			check_equal("drs_srclk after reset", 32'(drs_srclk), 0);
			check_equal("busy after reset", 32'(busy), 0);
		end

		run_event(0, 0, 0);
		run_event(1, 0, 0);
		run_event(2, 0, 0);
		run_event(3, 1, 0);
		run_event(4, 1, 1);
		run_event(5, 1, 0);

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== drs_readout_top.sv ====
`timescale 1ns/1ns

module drs_readout_top (
	input logic AD9222_FCO_P,
	input logic rst,
	input logic trig,
	input logic [drs_readout_pkg::N_CHIP-1:0] drs_srout,
	input drs_readout_pkg::adc_sample_t [drs_readout_pkg::N_CHIP-1:0] adc_data,
	input logic tx_full,
	output logic drs_rsrload,
	output logic drs_srclk,
	output logic [7:0] tx_data,
	output logic tx_wr,
	output logic busy
);
	import drs_readout_pkg::*;

	// sequencer strobes
	logic cell_strobe;
	logic read_mark;
	sample_index_t read_index;

	// strobes realigned to the adc output
	logic write_en;
	sample_index_t write_index;

	stop_cell_t [N_CHIP-1:0] stop_cells;
	sample_index_t rd_index;
	chip_index_t rd_chip;
	adc_sample_t rd_data;
	logic event_done;

	readout_sequencer readout_sequencer_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.rst(rst),
		.trig(trig),
		.event_done(event_done),
		.drs_rsrload(drs_rsrload),
		.drs_srclk(drs_srclk),
		.cell_strobe(cell_strobe),
		.read_mark(read_mark),
		.read_index(read_index),
		.busy(busy)
	);

	stop_cell_shifter stop_cell_shifter_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.rst(rst),
		.drs_rsrload(drs_rsrload),
		.cell_strobe(cell_strobe),
		.drs_srout(drs_srout),
		.stop_cells(stop_cells)
	);

	// match the adc pipeline
	delay_line #(
		.T(logic),
		.DEPTH(ADC_LATENCY)
	) mark_delay_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.rst(rst),
		.din(read_mark),
		.dout(write_en)
	);

	delay_line #(
		.T(sample_index_t),
		.DEPTH(ADC_LATENCY)
	) index_delay_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.rst(rst),
		.din(read_index),
		.dout(write_index)
	);

	sample_buffer sample_buffer_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.write_en(write_en),
		.write_index(write_index),
		.adc_data(adc_data),
		.rd_index(rd_index),
		.rd_chip(rd_chip),
		.rd_data(rd_data)
	);

	event_formatter event_formatter_i (
		.AD9222_FCO_P(AD9222_FCO_P),
		.rst(rst),
		.write_en(write_en),
		.write_index(write_index),
		.stop_cells(stop_cells),
		.rd_data(rd_data),
		.tx_full(tx_full),
		.rd_index(rd_index),
		.rd_chip(rd_chip),
		.tx_data(tx_data),
		.tx_wr(tx_wr),
		.event_done(event_done)
	);

endmodule

// ==== event_formatter.sv ====
`timescale 1ns/1ns

module event_formatter (
	input logic AD9222_FCO_P,
	input logic rst,
	input logic write_en,
	input drs_readout_pkg::sample_index_t write_index,
	input drs_readout_pkg::stop_cell_t [drs_readout_pkg::N_CHIP-1:0] stop_cells,
	input drs_readout_pkg::adc_sample_t rd_data,
	input logic tx_full,
	output drs_readout_pkg::sample_index_t rd_index,
	output drs_readout_pkg::chip_index_t rd_chip,
	output logic [7:0] tx_data,
	output logic tx_wr,
	output logic event_done
);
	import drs_readout_pkg::*;

	typedef enum logic [2:0] {
		fmt_idle,
		fmt_head,
		fmt_count,
		fmt_cells,
		fmt_samples,
		fmt_trail
	} state_t;

	// state names the byte currently held in tx_data
	state_t state;
	logic byte_valid;
	logic [7:0] event_cnt;
	chip_index_t cell_chip;
	logic lo_sel;
	logic last_sample;
	logic [7:0] lo_hold;

	// the fifo takes a byte whenever it is not full
	assign tx_wr = byte_valid & ~tx_full;

	always_ff @(posedge AD9222_FCO_P) begin
		if (rst) begin
			state <= fmt_idle;
			byte_valid <= 1'b0;
			event_done <= 1'b0;
			event_cnt <= '0;
			cell_chip <= '0;
			rd_index <= '0;
			rd_chip <= '0;
			lo_sel <= 1'b0;
			last_sample <= 1'b0;
		end else begin
			event_done <= 1'b0;
			if (event_done) begin
				event_cnt <= event_cnt + 8'd1;
			end
			case (state)
				fmt_idle: begin
					// last row is in the buffer
					if (write_en && write_index == sample_index_t'(READ_DEPTH - 1)) begin
						tx_data <= HEADER_BYTE;
						byte_valid <= 1'b1;
						cell_chip <= '0;
						rd_index <= '0;
						rd_chip <= '0;
						lo_sel <= 1'b0;
						last_sample <= 1'b0;
						state <= fmt_head;
					end
				end
				fmt_head: begin
					if (tx_wr) begin
						tx_data <= event_cnt;
						state <= fmt_count;
					end
				end
				fmt_count: begin
					if (tx_wr) begin
						tx_data <= 8'(stop_cells[0] >> 8);
						lo_sel <= 1'b0;
						state <= fmt_cells;
					end
				end
				fmt_cells: begin
					if (tx_wr) begin
						if (!lo_sel) begin
							tx_data <= stop_cells[cell_chip][7:0];
							lo_sel <= 1'b1;
						end else if (cell_chip == chip_index_t'(N_CHIP - 1)) begin
							// sample 0 of channel 0 is waiting on rd_data
							tx_data <= 8'(rd_data >> 8);
							lo_hold <= rd_data[7:0];
							lo_sel <= 1'b0;
							rd_chip <= rd_chip + 1'b1;
							state <= fmt_samples;
						end else begin
							tx_data <= 8'(stop_cells[cell_chip + 1'b1] >> 8);
							cell_chip <= cell_chip + 1'b1;
							lo_sel <= 1'b0;
						end
					end
				end
				fmt_samples: begin
					if (tx_wr) begin
						if (!lo_sel) begin
							tx_data <= lo_hold;
							lo_sel <= 1'b1;
						end else if (last_sample) begin
							tx_data <= TRAILER_BYTE;
							state <= fmt_trail;
						end else begin
							tx_data <= 8'(rd_data >> 8);
							lo_hold <= rd_data[7:0];
							lo_sel <= 1'b0;
							// step the read address one sample ahead
							if (rd_chip == chip_index_t'(N_CHIP - 1)) begin
								if (rd_index == sample_index_t'(READ_DEPTH - 1)) begin
									last_sample <= 1'b1;
								end else begin
									rd_chip <= '0;
									rd_index <= rd_index + 1'b1;
								end
							end else begin
								rd_chip <= rd_chip + 1'b1;
							end
						end
					end
				end
				fmt_trail: begin
					if (tx_wr) begin
						byte_valid <= 1'b0;
						event_done <= 1'b1;
						state <= fmt_idle;
					end
				end
				default: begin
					byte_valid <= 1'b0;
					state <= fmt_idle;
				end
			endcase
		end
	end

endmodule

// ==== sample_buffer.sv ====
`timescale 1ns/1ns

module sample_buffer (
	input logic AD9222_FCO_P,
	input logic write_en,
	input drs_readout_pkg::sample_index_t write_index,
	input drs_readout_pkg::adc_sample_t [drs_readout_pkg::N_CHIP-1:0] adc_data,
	input drs_readout_pkg::sample_index_t rd_index,
	input drs_readout_pkg::chip_index_t rd_chip,
	output drs_readout_pkg::adc_sample_t rd_data
);
	import drs_readout_pkg::*;

	// one row per readout strobe, all channels side by side
	adc_sample_t [N_CHIP-1:0] mem [READ_DEPTH];

	always_ff @(posedge AD9222_FCO_P) begin
		if (write_en) begin
			mem[write_index] <= adc_data;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge AD9222_FCO_P) begin
		rd_data <= mem[rd_index][rd_chip];
	end

endmodule

// ==== delay_line.sv ====
`timescale 1ns/1ns

module delay_line #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input logic AD9222_FCO_P,
	input logic rst,
	input T din,
	output T dout
);

	T pipe [DEPTH];

	// one register per cycle of delay
	always_ff @(posedge AD9222_FCO_P) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign dout = pipe[DEPTH-1];

endmodule

// ==== stop_cell_shifter.sv ====
`timescale 1ns/1ns

module stop_cell_shifter (
	input logic AD9222_FCO_P,
	input logic rst,
	input logic drs_rsrload,
	input logic cell_strobe,
	input logic [drs_readout_pkg::N_CHIP-1:0] drs_srout,
	output drs_readout_pkg::stop_cell_t [drs_readout_pkg::N_CHIP-1:0] stop_cells
);
	import drs_readout_pkg::*;

	// chip drives the next bit one cycle after load or clock
	logic capture;

	always_ff @(posedge AD9222_FCO_P) begin
		if (rst) begin
			capture <= 1'b0;
		end else begin
			capture <= drs_rsrload | cell_strobe;
		end
	end

	// msb arrives first, shift in from the bottom
	always_ff @(posedge AD9222_FCO_P) begin
		if (capture) begin
			for (int c = 0; c < N_CHIP; c++) begin
				stop_cells[c] <= {stop_cells[c][CELL_W-2:0], drs_srout[c]};
			end
		end
	end

endmodule

// ==== readout_sequencer.sv ====
`timescale 1ns/1ns

module readout_sequencer (
	input logic AD9222_FCO_P,
	input logic rst,
	input logic trig,
	input logic event_done,
	output logic drs_rsrload,
	output logic drs_srclk,
	output logic cell_strobe,
	output logic read_mark,
	output drs_readout_pkg::sample_index_t read_index,
	output logic busy
);
	import drs_readout_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_cells,
		st_read,
		st_wait
	} state_t;

	state_t state;
	logic trig_q;
	logic trig_rise;
	logic [$clog2(CELL_W)-1:0] cell_cnt;

	assign trig_rise = trig & ~trig_q;

	always_ff @(posedge AD9222_FCO_P) begin
		if (rst) begin
			state <= st_idle;
			trig_q <= 1'b0;
			cell_cnt <= '0;
			drs_rsrload <= 1'b0;
			drs_srclk <= 1'b0;
			cell_strobe <= 1'b0;
			read_mark <= 1'b0;
			read_index <= '0;
			busy <= 1'b0;
		end else begin
			trig_q <= trig;
			case (state)
				st_idle: begin
					// edges seen outside idle are dropped
					if (trig_rise) begin
						drs_rsrload <= 1'b1;
						busy <= 1'b1;
						state <= st_load;
					end
				end
				st_load: begin
					drs_rsrload <= 1'b0;
					drs_srclk <= 1'b1;
					cell_strobe <= 1'b1;
					cell_cnt <= '0;
					state <= st_cells;
				end
				st_cells: begin
					// bit 9 came with the load, so only CELL_W-1 clocks
					if (int'(cell_cnt) == CELL_W - 2) begin
						cell_strobe <= 1'b0;
						read_mark <= 1'b1;
						read_index <= '0;
						state <= st_read;
					end else begin
						cell_cnt <= cell_cnt + 1'b1;
					end
				end
				st_read: begin
					if (read_index == sample_index_t'(READ_DEPTH - 1)) begin
						drs_srclk <= 1'b0;
						read_mark <= 1'b0;
						state <= st_wait;
					end else begin
						read_index <= read_index + 1'b1;
					end
				end
				st_wait: begin
					// hold off triggers until the event has left
					if (event_done) begin
						busy <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== drs_readout_pkg.sv ====
package drs_readout_pkg;

	// board geometry
	localparam int N_CHIP = 8;
	localparam int CELL_W = 10;
	localparam int ADC_W = 12;

	// samples per channel and event
	localparam int READ_DEPTH = 30;

	// frame clocks from readout strobe to sample at the ADC output
	localparam int ADC_LATENCY = 17;

	// event framing
	localparam logic [7:0] HEADER_BYTE = 8'hEB;
	localparam logic [7:0] TRAILER_BYTE = 8'h75;

	// header, counter, stop cells, samples, trailer
	localparam int EVENT_BYTES = 2 + 2 * N_CHIP + 2 * N_CHIP * READ_DEPTH + 1;

	typedef logic [ADC_W-1:0] adc_sample_t;

	typedef logic [CELL_W-1:0] stop_cell_t;

	// readout position 0 .. READ_DEPTH-1
	typedef logic [$clog2(READ_DEPTH)-1:0] sample_index_t;

	// chip number, same as the ADC channel number
	typedef logic [$clog2(N_CHIP)-1:0] chip_index_t;

endpackage
